/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing -Wno-fatal
TOP       = tb_hs_decode
FILELIST  = hs_decode.f
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, fail on a failing log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "Checks failed" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "All checks passed" $(LOG) || (echo "Simulation gave no result"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

/* hs_decode.f */
+incdir+source
source/hs_decode_pkg.sv
source/decode_control.sv
source/instr_decoder.sv
source/trap_unit.sv
source/hs_decode_top.sv
testbench/tb_hs_decode.sv

/* source/decode_control.sv */
/*
 Handshake control. One instruction in flight, so at best one fetch every 2 cycles.
 A trapping fetch sets halt; reqd and reqe then stay low until reset.
*/
`timescale 1ns/1ps
`default_nettype none

module decode_control (
    input  wire  clk,
    input  wire  reset,
    input  wire  rdyd,
    input  wire  rdye,
    input  wire  is_trap,
    output logic reqd,
    output logic reqe,
    output logic load
);

    logic full;         // Decoded uop waiting for execute
    logic halt;
    logic full_next;
    logic halt_next;

    assign load = reqd && rdyd;     // Fetch transfer

    always_comb begin
        full_next = full;
        halt_next = halt || (load && is_trap);
        if (load && !is_trap) begin
            full_next = 1'b1;
        end else if (reqe && rdye) begin
            full_next = 1'b0;       // Execute took the uop
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            full <= 1'b0;
            halt <= 1'b0;
            reqd <= 1'b0;
            reqe <= 1'b0;
        end else begin
            full <= full_next;
            halt <= halt_next;
            reqd <= !halt_next && !full_next;
            reqe <= !halt_next && full_next;
        end
    end

endmodule

`default_nettype wire

/* source/hs_decode_params.svh */
/*
 Widths, instruction field positions, opcode map and ALU codes of the decode stage.
 Field positions are bit ranges meant for part-selects of the instruction word.
 Branch opcodes give only the upper nibble; the low nibble is the condition.
*/
`ifndef HS_DECODE_PARAMS_SVH
`define HS_DECODE_PARAMS_SVH

`define HS_INSTR_W      32
`define HS_REG_W        4
`define HS_IMM_W        16
`define HS_SHIFT_W      5
`define HS_INT_LINES    24
`define HS_ALU_W        4
`define HS_BANK_W       2

// Instruction word fields
`define HS_F_OP         31:24
`define HS_F_RD         23:20
`define HS_F_RM         19:16
`define HS_F_RN         15:12
`define HS_F_SHIFT      11:7
`define HS_F_SDIR       6:5
`define HS_F_BANK       4:3
`define HS_F_IMM        15:0
`define HS_F_COND       27:24

`define HS_OP_LDRI      8'h10
`define HS_OP_LDR       8'h11
`define HS_OP_LDRA      8'h12
`define HS_OP_STRI      8'h20
`define HS_OP_STR       8'h21
`define HS_OP_STRA      8'h22
`define HS_OP_MOVI      8'h30
`define HS_OP_MOVN      8'h31
`define HS_OP_MOV       8'h32
`define HS_OP_MOVR      8'h33
`define HS_OP_ADD       8'h40
`define HS_OP_ADDC      8'h41
`define HS_OP_SUB       8'h42
`define HS_OP_RSUB      8'h43
`define HS_OP_SUBC      8'h44
`define HS_OP_RSUBC     8'h45
`define HS_OP_ADDI      8'h48
`define HS_OP_ADDIC     8'h49
`define HS_OP_SUBI      8'h4A
`define HS_OP_RSUBI     8'h4B
`define HS_OP_SUBIC     8'h4C
`define HS_OP_RSUBIC    8'h4D
`define HS_OP_AND       8'h60
`define HS_OP_BIC       8'h61
`define HS_OP_OR        8'h62
`define HS_OP_XOR       8'h63
`define HS_OP_ANDI      8'h68
`define HS_OP_BICI      8'h69
`define HS_OP_ORI       8'h6A
`define HS_OP_XORI      8'h6B
`define HS_OP_CMP       8'h70
`define HS_OP_TST       8'h71
`define HS_OP_CMPI      8'h78
`define HS_OP_TSTI      8'h79
`define HS_OP_BRCH      4'h8    // Upper nibble only
`define HS_OP_BRCL      4'h9    // Upper nibble only
`define HS_OP_INT       8'hF0

`define HS_ALU_ADD      4'd0
`define HS_ALU_SUB      4'd1
`define HS_ALU_ADC      4'd2
`define HS_ALU_SBC      4'd3
`define HS_ALU_AND      4'd4
`define HS_ALU_BIC      4'd5
`define HS_ALU_OR       4'd6
`define HS_ALU_XOR      4'd7
`define HS_ALU_MOV      4'd8

`endif

/* source/hs_decode_pkg.sv */
/*
 Decode stage types. The control word keeps the bit layout that execute expects,
 with wb in the top two bits and bank_en in bit 0.
 The spare bit of the control word is always driven to zero.
*/
`default_nettype none

`include "hs_decode_params.svh"

package hs_decode_pkg;

    typedef enum logic [1:0] {
        WB_NONE  = 2'd0,    // Compare, test, branch
        WB_REG   = 2'd1,    // Move, math, logic
        WB_LOAD  = 2'd2,
        WB_STORE = 2'd3
    } wb_sel_t;

    typedef enum logic [2:0] {
        SRC_BRANCH    = 3'd0,
        SRC_IMM       = 3'd1,   // MOVI
        SRC_RM_IMM    = 3'd2,   // Immediate and plain forms
        SRC_RM_SHRN   = 3'd3,   // Register forms
        SRC_SHRN      = 3'd4,   // MOVN
        SRC_STORE_IMM = 3'd5,   // STRI, STR
        SRC_STORE_REG = 3'd6    // STRA
    } src_sel_t;

    typedef struct packed {
        wb_sel_t    wb;
        logic       reverse;    // Swapped operands
        src_sel_t   src;
        logic [3:0] cond;       // Branch condition
        logic       bank_dst;   // Banked destination
        logic       set_flags;
        logic       spare;
        logic [1:0] shift_dir;
        logic       bank_en;
    } ctl_t;

    typedef struct packed {
        logic [`HS_ALU_W-1:0]   aluop;
        logic [`HS_SHIFT_W-1:0] shift;
        logic [`HS_IMM_W-1:0]   imm;
        logic [`HS_REG_W-1:0]   rd;
        logic [`HS_REG_W-1:0]   rm;
        logic [`HS_REG_W-1:0]   rn;
        logic [`HS_BANK_W-1:0]  bank;
        ctl_t                   ctl;
    } uop_t;

    typedef enum logic [1:0] {
        TRAP_NONE  = 2'd0,
        TRAP_INT   = 2'd1,
        TRAP_UNDEF = 2'd2
    } trap_kind_t;

    typedef struct packed {
        trap_kind_t           kind;
        logic [`HS_IMM_W-1:0] vector;
    } trap_t;

endpackage

`default_nettype wire

/* source/hs_decode_top.sv */
/*
 Decode stage top. Fetch side is reqd/rdyd, execute side is reqe/rdye.
 uop is valid while reqe is high and holds until the execute transfer.
*/
`timescale 1ns/1ps
`default_nettype none

`include "hs_decode_params.svh"

module hs_decode_top (
    input  wire                         clk,
    input  wire                         reset,
    input  wire [`HS_INSTR_W-1:0]       instd,
    input  wire                         rdyd,
    input  wire                         rdye,
    output logic                        reqd,
    output logic                        reqe,
    output hs_decode_pkg::uop_t         uop,
    output logic [`HS_INT_LINES-1:0]    int_line
);

    logic                   load;
    logic                   is_trap;
    hs_decode_pkg::trap_t   trap_next;

    decode_control u_control (
        .clk     (clk),
        .reset   (reset),
        .rdyd    (rdyd),
        .rdye    (rdye),
        .is_trap (is_trap),
        .reqd    (reqd),
        .reqe    (reqe),
        .load    (load)
    );

    instr_decoder u_decoder (
        .clk       (clk),
        .reset     (reset),
        .instd     (instd),
        .load      (load),
        .uop       (uop),
        .trap_next (trap_next),
        .is_trap   (is_trap)
    );

    trap_unit u_trap (
        .clk       (clk),
        .reset     (reset),
        .load      (load),
        .trap_next (trap_next),
        .int_line  (int_line)
    );

endmodule

`default_nettype wire

/* source/instr_decoder.sv */
/*
 Opcode table and micro-op register. Fields a form does not use are driven to zero.
 BRCL routes the rn field into rm. INT and undefined opcodes, MUL among them,
 leave the uop register unchanged and only form a trap request.
*/
`timescale 1ns/1ps
`default_nettype none

`include "hs_decode_params.svh"

module instr_decoder (
    input  wire                      clk,
    input  wire                      reset,
    input  wire [`HS_INSTR_W-1:0]    instd,
    input  wire                      load,
    output hs_decode_pkg::uop_t      uop,
    output hs_decode_pkg::trap_t     trap_next,
    output logic                     is_trap
);

    typedef struct packed {
        logic shift;
        logic imm;
        logic rd;
        logic rm;
        logic rn;
        logic bank;
        logic sdir;
    } field_use_t;

    // Field sets of the instruction forms
    localparam field_use_t F_NONE = '{shift: 0, imm: 0, rd: 0, rm: 0, rn: 0, bank: 0, sdir: 0};
    localparam field_use_t F_RM_IMM = '{shift: 0, imm: 1, rd: 1, rm: 1, rn: 0, bank: 0, sdir: 0};
    localparam field_use_t F_RM = '{shift: 0, imm: 0, rd: 1, rm: 1, rn: 0, bank: 0, sdir: 0};
    localparam field_use_t F_REG = '{shift: 1, imm: 0, rd: 1, rm: 1, rn: 1, bank: 0, sdir: 1};
    localparam field_use_t F_IMM = '{shift: 0, imm: 1, rd: 1, rm: 0, rn: 0, bank: 0, sdir: 0};
    localparam field_use_t F_SHRN = '{shift: 1, imm: 0, rd: 1, rm: 0, rn: 1, bank: 0, sdir: 1};
    localparam field_use_t F_BANK = '{shift: 0, imm: 0, rd: 1, rm: 1, rn: 0, bank: 1, sdir: 0};
    localparam field_use_t F_CMP = '{shift: 1, imm: 0, rd: 0, rm: 1, rn: 1, bank: 0, sdir: 1};
    localparam field_use_t F_CMPI = '{shift: 0, imm: 1, rd: 0, rm: 1, rn: 0, bank: 0, sdir: 0};
    localparam field_use_t F_BRCH = '{shift: 0, imm: 1, rd: 0, rm: 0, rn: 0, bank: 0, sdir: 0};

    logic [7:0]             op;
    logic [`HS_ALU_W-1:0]   aluop;
    hs_decode_pkg::ctl_t    ctl;
    field_use_t             use_f;
    logic                   rm_from_rn;
    logic                   undef;
    logic                   is_int;
    hs_decode_pkg::uop_t    uop_next;

    function automatic logic [`HS_ALU_W-1:0] arith_alu(input logic [2:0] sel);
        case (sel)
            3'd1: return `HS_ALU_ADC;
            3'd2, 3'd3: return `HS_ALU_SUB;
            3'd4, 3'd5: return `HS_ALU_SBC;
            default: return `HS_ALU_ADD;
        endcase
    endfunction

    function automatic logic [`HS_ALU_W-1:0] logic_alu(input logic [1:0] sel);
        case (sel)
            2'd1: return `HS_ALU_BIC;
            2'd2: return `HS_ALU_OR;
            2'd3: return `HS_ALU_XOR;
            default: return `HS_ALU_AND;
        endcase
    endfunction

    assign op = instd[`HS_F_OP];

    always_comb begin
        aluop      = `HS_ALU_ADD;
        ctl        = '0;
        use_f      = F_NONE;
        rm_from_rn = 1'b0;
        undef      = 1'b0;
        is_int     = 1'b0;
        casez (op)
            `HS_OP_LDRI, `HS_OP_LDR, `HS_OP_LDRA: begin
                ctl.wb  = hs_decode_pkg::WB_LOAD;
                ctl.src = (op == `HS_OP_LDRA) ? hs_decode_pkg::SRC_RM_SHRN
                                              : hs_decode_pkg::SRC_RM_IMM;
                use_f   = (op == `HS_OP_LDRI) ? F_RM_IMM : (op == `HS_OP_LDR) ? F_RM : F_REG;
            end
            `HS_OP_STRI, `HS_OP_STR, `HS_OP_STRA: begin
                ctl.wb  = hs_decode_pkg::WB_STORE;
                ctl.src = (op == `HS_OP_STRA) ? hs_decode_pkg::SRC_STORE_REG
                                              : hs_decode_pkg::SRC_STORE_IMM;
                use_f   = (op == `HS_OP_STRI) ? F_RM_IMM : (op == `HS_OP_STR) ? F_RM : F_REG;
            end
            `HS_OP_MOVI: begin
                aluop   = `HS_ALU_MOV;
                ctl.wb  = hs_decode_pkg::WB_REG;
                ctl.src = hs_decode_pkg::SRC_IMM;
                use_f   = F_IMM;
            end
            `HS_OP_MOVN: begin
                aluop   = `HS_ALU_MOV;
                ctl.wb  = hs_decode_pkg::WB_REG;
                ctl.src = hs_decode_pkg::SRC_SHRN;
                use_f   = F_SHRN;
            end
            `HS_OP_MOV, `HS_OP_MOVR: begin
                aluop        = `HS_ALU_MOV;
                ctl.wb       = hs_decode_pkg::WB_REG;
                ctl.src      = hs_decode_pkg::SRC_RM_IMM;
                ctl.bank_en  = 1'b1;
                ctl.bank_dst = (op == `HS_OP_MOVR);    // Rd is the banked one
                use_f        = F_BANK;
            end
            `HS_OP_ADD, `HS_OP_ADDC, `HS_OP_SUB, `HS_OP_RSUB, `HS_OP_SUBC, `HS_OP_RSUBC,
            `HS_OP_ADDI, `HS_OP_ADDIC, `HS_OP_SUBI, `HS_OP_RSUBI, `HS_OP_SUBIC,
            `HS_OP_RSUBIC: begin
                aluop         = arith_alu(op[2:0]);
                ctl.wb        = hs_decode_pkg::WB_REG;
                ctl.reverse   = (op[2:0] == 3'd3) || (op[2:0] == 3'd5);
                ctl.set_flags = 1'b1;
                ctl.src       = op[3] ? hs_decode_pkg::SRC_RM_IMM : hs_decode_pkg::SRC_RM_SHRN;
                use_f         = op[3] ? F_RM_IMM : F_REG;     // Bit 3 marks the immediate form
            end
            `HS_OP_AND, `HS_OP_BIC, `HS_OP_OR, `HS_OP_XOR,
            `HS_OP_ANDI, `HS_OP_BICI, `HS_OP_ORI, `HS_OP_XORI: begin
                aluop         = logic_alu(op[1:0]);
                ctl.wb        = hs_decode_pkg::WB_REG;
                ctl.set_flags = 1'b1;
                ctl.src       = op[3] ? hs_decode_pkg::SRC_RM_IMM : hs_decode_pkg::SRC_RM_SHRN;
                use_f         = op[3] ? F_RM_IMM : F_REG;
            end
            `HS_OP_CMP, `HS_OP_TST, `HS_OP_CMPI, `HS_OP_TSTI: begin
                aluop         = op[0] ? `HS_ALU_AND : `HS_ALU_SUB;     // TST or CMP
                ctl.set_flags = 1'b1;
                ctl.src       = op[3] ? hs_decode_pkg::SRC_RM_IMM : hs_decode_pkg::SRC_RM_SHRN;
                use_f         = op[3] ? F_CMPI : F_CMP;
            end
            {`HS_OP_BRCH, 4'b????}: begin
                ctl.src  = hs_decode_pkg::SRC_BRANCH;
                ctl.cond = instd[`HS_F_COND];
                use_f    = F_BRCH;
            end
            {`HS_OP_BRCL, 4'b????}: begin
                aluop       = `HS_ALU_MOV;
                ctl.wb      = hs_decode_pkg::WB_REG;   // Link register write
                ctl.reverse = 1'b1;
                ctl.src     = hs_decode_pkg::SRC_RM_IMM;
                ctl.cond    = instd[`HS_F_COND];
                use_f       = F_IMM;
                rm_from_rn  = 1'b1;
            end
            `HS_OP_INT: is_int = 1'b1;
            default: undef = 1'b1;
        endcase
        if (use_f.sdir) begin
            ctl.shift_dir = instd[`HS_F_SDIR];
        end
    end

    always_comb begin
        uop_next       = '0;
        uop_next.aluop = aluop;
        uop_next.ctl   = ctl;
        if (use_f.shift) begin
            uop_next.shift = instd[`HS_F_SHIFT];
        end
        if (use_f.imm) begin
            uop_next.imm = instd[`HS_F_IMM];
        end
        if (use_f.rd) begin
            uop_next.rd = instd[`HS_F_RD];
        end
        if (use_f.rm) begin
            uop_next.rm = instd[`HS_F_RM];
        end else if (rm_from_rn) begin
            uop_next.rm = instd[`HS_F_RN];
        end
        if (use_f.rn) begin
            uop_next.rn = instd[`HS_F_RN];
        end
        if (use_f.bank) begin
            uop_next.bank = instd[`HS_F_BANK];
        end
    end

    always_comb begin
        trap_next = '0;
        if (undef) begin
            trap_next.kind = hs_decode_pkg::TRAP_UNDEF;
        end else if (is_int) begin
            trap_next.kind   = hs_decode_pkg::TRAP_INT;
            trap_next.vector = instd[`HS_F_IMM];
        end
    end

    assign is_trap = undef || is_int;

    always_ff @(posedge clk) begin
        if (reset) begin
            uop <= '0;
        end else if (load && !is_trap) begin
            uop <= uop_next;
        end
    end

endmodule

`default_nettype wire

/* source/trap_unit.sv */
/*
 Interrupt line driver. Each trap gives a one-cycle pulse the cycle after the fetch.
 INT vectors of 24 and above pulse no line; undefined opcodes pulse line 0.
*/
`timescale 1ns/1ps
`default_nettype none

`include "hs_decode_params.svh"

module trap_unit (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         load,
    input  wire hs_decode_pkg::trap_t   trap_next,
    output logic [`HS_INT_LINES-1:0]    int_line
);

    hs_decode_pkg::trap_t trap_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            trap_q <= '0;
        end else if (load) begin
            trap_q <= trap_next;
        end else begin
            trap_q <= '0;   // Drop after one cycle
        end
    end

    always_comb begin
        int_line = '0;
        case (trap_q.kind)
            hs_decode_pkg::TRAP_UNDEF: int_line[0] = 1'b1;
            // Shift past the top leaves all lines low
            hs_decode_pkg::TRAP_INT: int_line = `HS_INT_LINES'(1) << trap_q.vector;
            default: int_line = '0;
        endcase
    end

endmodule

`default_nettype wire

/* testbench/tb_hs_decode.sv */
/*
 Testbench for the decode stage. Inputs change on the falling clock edge and
 outputs are sampled 1 ns after it. Expected uops come from a reference decoder
 built from the opcode map; random words come from a 32-bit LFSR.
*/
`timescale 1ns/1ps
`default_nettype none

`include "hs_decode_params.svh"

module tb_hs_decode;

    localparam int WAIT_LIMIT  = 200;   // Cycles allowed for any handshake wait
    localparam int HALT_CYCLES = 20;
    localparam int N_OPS       = 36;

    logic                       clk;
    logic                       reset;
    logic [`HS_INSTR_W-1:0]     instd;
    logic                       rdyd;
    logic                       rdye;
    logic                       reqd;
    logic                       reqe;
    hs_decode_pkg::uop_t        uop;
    logic [`HS_INT_LINES-1:0]   int_line;

    logic [31:0]                lfsr;
    logic [7:0]                 op_table [0:N_OPS-1];
    hs_decode_pkg::uop_t        exp_q [$];
    hs_decode_pkg::uop_t        held_uop;
    logic                       held_valid;     // uop offered but not yet taken
    logic                       fetch_waiting;  // reqd high and fetch not ready
    logic                       mon_en;
    logic                       bp_en;          // Random back-pressure
    int                         rdye_left;
    int                         errors;
    int                         checks;
    int                         test_num;
    int                         test_errors;
    int                         idx;
    int                         vec;

    hs_decode_top DUT (
        .clk      (clk),
        .reset    (reset),
        .instd    (instd),
        .rdyd     (rdyd),
        .rdye     (rdye),
        .reqd     (reqd),
        .reqe     (reqe),
        .uop      (uop),
        .int_line (int_line)
    );

    always #10 clk = ~clk;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic rand_bit();
        lfsr = lfsr_next(lfsr);
        return lfsr[0];
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], rand_bit()};
        end
        return r;
    endfunction

    function automatic logic [3:0] alu_ref(input logic [7:0] op);
        case (op)
            `HS_OP_ADDC, `HS_OP_ADDIC: return `HS_ALU_ADC;
            `HS_OP_SUB, `HS_OP_RSUB, `HS_OP_SUBI, `HS_OP_RSUBI: return `HS_ALU_SUB;
            `HS_OP_CMP, `HS_OP_CMPI: return `HS_ALU_SUB;
            `HS_OP_SUBC, `HS_OP_RSUBC, `HS_OP_SUBIC, `HS_OP_RSUBIC: return `HS_ALU_SBC;
            `HS_OP_AND, `HS_OP_ANDI, `HS_OP_TST, `HS_OP_TSTI: return `HS_ALU_AND;
            `HS_OP_BIC, `HS_OP_BICI: return `HS_ALU_BIC;
            `HS_OP_OR, `HS_OP_ORI: return `HS_ALU_OR;
            `HS_OP_XOR, `HS_OP_XORI: return `HS_ALU_XOR;
            default: return `HS_ALU_ADD;
        endcase
    endfunction

    // Expected uop of a kept opcode; unused fields stay zero
    function automatic hs_decode_pkg::uop_t decode_ref(input logic [31:0] ins);
        hs_decode_pkg::uop_t u;
        logic [7:0]          op;
        logic                shifted;   // Shifted rn operand in use
        op      = ins[`HS_F_OP];
        u       = '0;
        shifted = 1'b0;
        case (op[7:4])
            4'h1, 4'h2: begin
                u.rd    = ins[`HS_F_RD];
                u.rm    = ins[`HS_F_RM];
                shifted = (op[3:0] == 4'h2);
                if (op[3:0] == 4'h0) u.imm = ins[`HS_F_IMM];
                if (op[7:4] == 4'h1) begin
                    u.ctl.wb  = hs_decode_pkg::WB_LOAD;
                    u.ctl.src = shifted ? hs_decode_pkg::SRC_RM_SHRN : hs_decode_pkg::SRC_RM_IMM;
                end else begin
                    u.ctl.wb  = hs_decode_pkg::WB_STORE;
                    u.ctl.src = shifted ? hs_decode_pkg::SRC_STORE_REG
                                        : hs_decode_pkg::SRC_STORE_IMM;
                end
            end
            4'h3: begin
                u.aluop  = `HS_ALU_MOV;
                u.ctl.wb = hs_decode_pkg::WB_REG;
                u.rd     = ins[`HS_F_RD];
                if (op == `HS_OP_MOVI) begin
                    u.ctl.src = hs_decode_pkg::SRC_IMM;
                    u.imm     = ins[`HS_F_IMM];
                end else if (op == `HS_OP_MOVN) begin
                    u.ctl.src = hs_decode_pkg::SRC_SHRN;
                    shifted   = 1'b1;
                end else begin
                    u.ctl.src      = hs_decode_pkg::SRC_RM_IMM;
                    u.ctl.bank_en  = 1'b1;
                    u.ctl.bank_dst = (op == `HS_OP_MOVR);
                    u.rm           = ins[`HS_F_RM];
                    u.bank         = ins[`HS_F_BANK];
                end
            end
            4'h4, 4'h6, 4'h7: begin
                u.aluop         = alu_ref(op);
                u.ctl.set_flags = 1'b1;
                u.ctl.reverse   = (op == `HS_OP_RSUB) || (op == `HS_OP_RSUBC) ||
                                  (op == `HS_OP_RSUBI) || (op == `HS_OP_RSUBIC);
                u.rm            = ins[`HS_F_RM];
                if (op[7:4] != 4'h7) begin     // Compare and test write nothing
                    u.ctl.wb = hs_decode_pkg::WB_REG;
                    u.rd     = ins[`HS_F_RD];
                end
                if (op[3]) begin
                    u.ctl.src = hs_decode_pkg::SRC_RM_IMM;
                    u.imm     = ins[`HS_F_IMM];
                end else begin
                    u.ctl.src = hs_decode_pkg::SRC_RM_SHRN;
                    shifted   = 1'b1;
                end
            end
            4'h8, 4'h9: begin
                u.ctl.src  = hs_decode_pkg::SRC_BRANCH;
                u.ctl.cond = op[3:0];
                u.imm      = ins[`HS_F_IMM];
                if (op[7:4] == `HS_OP_BRCL) begin
                    u.aluop       = `HS_ALU_MOV;
                    u.ctl.wb      = hs_decode_pkg::WB_REG;
                    u.ctl.reverse = 1'b1;
                    u.ctl.src     = hs_decode_pkg::SRC_RM_IMM;
                    u.rd          = ins[`HS_F_RD];   // Link register
                    u.rm          = ins[`HS_F_RN];
                end
            end
            default: u = '0;
        endcase
        if (shifted) begin
            u.rn            = ins[`HS_F_RN];
            u.shift         = ins[`HS_F_SHIFT];
            u.ctl.shift_dir = ins[`HS_F_SDIR];
        end
        return u;
    endfunction

    task automatic check_uop(input string name, input hs_decode_pkg::uop_t got,
                             input hs_decode_pkg::uop_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_lines(input string name, input logic [`HS_INT_LINES-1:0] got,
                               input logic [`HS_INT_LINES-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_ctl(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("Timeout: %s", what);
        $display("Checks failed");
        $finish;
    endtask

    // One clock and a new rdye level
    task automatic step();
        @(negedge clk);
        if (bp_en) begin
            if (rdye_left == 0) begin
                rdye      = rand_bit();
                rdye_left = int'(rand_bits(3)) + 1;
            end
            rdye_left--;
        end else begin
            rdye = 1'b1;
        end
    endtask

    task automatic fetch(input logic [31:0] instr, input logic expect_uop);
        int waited;
        waited = 0;
        instd  = instr;
        rdyd   = bp_en ? rand_bit() : 1'b1;
        while (!(reqd && rdyd)) begin
            if (waited == WAIT_LIMIT) stop_on_timeout("reqd never rose to take an instruction");
            step();
            rdyd = bp_en ? rand_bit() : 1'b1;
            waited++;
        end
        if (expect_uop) exp_q.push_back(decode_ref(instr));
        step();
        rdyd  = 1'b0;
        instd = '0;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            if (waited == WAIT_LIMIT) stop_on_timeout("execute never took the pending uops");
            step();
            waited++;
        end
        step();
    endtask

    task automatic apply_reset();
        mon_en = 1'b0;
        reset  = 1'b1;
        rdyd   = 1'b0;
        instd  = '0;
        exp_q.delete();
        for (int i = 0; i < 8; i++) begin
            step();
            check_ctl("reqd", reqd, 1'b0);
            check_ctl("reqe", reqe, 1'b0);
            check_lines("int_line", int_line, '0);
        end
        reset = 1'b0;
        step();
        check_ctl("reqd", reqd, 1'b1);
        check_ctl("reqe", reqe, 1'b0);
        check_lines("int_line", int_line, '0);
    endtask

    task automatic trap_case(input logic [31:0] instr, input logic [`HS_INT_LINES-1:0] line);
        apply_reset();
        fetch(instr, 1'b0);
        check_lines("int_line", int_line, line);   // Pulse in the cycle after the fetch
        check_ctl("reqd", reqd, 1'b0);
        check_ctl("reqe", reqe, 1'b0);
        for (int i = 0; i < HALT_CYCLES; i++) begin
            step();
            check_lines("int_line", int_line, '0);
            check_ctl("reqd", reqd, 1'b0);
            check_ctl("reqe", reqe, 1'b0);
        end
        apply_reset();
    endtask

    task automatic begin_test();
        test_num++;
        test_errors = errors;
        held_valid    = 1'b0;
        fetch_waiting = 1'b0;
    endtask

    task automatic end_test(input string name);
        if (errors == test_errors) begin
            $display("test %0d %s: ok", test_num, name);
        end else begin
            $display("test %0d %s: %0d errors", test_num, name, errors - test_errors);
        end
    endtask

    function automatic logic [31:0] random_instr(input logic [7:0] opcode);
        logic [7:0]  op;
        logic [31:0] bits;
        op   = opcode;
        bits = rand_bits(28);
        if (op[7:4] == `HS_OP_BRCH || op[7:4] == `HS_OP_BRCL) op[3:0] = bits[27:24];
        return {op, bits[23:0]};
    endfunction

    function automatic logic [31:0] int_instr(input logic [15:0] vector);
        logic [31:0] bits;
        bits = rand_bits(8);
        return {`HS_OP_INT, bits[7:0], vector};
    endfunction

    // Execute side checks 1 ns after each falling edge
    always @(negedge clk) begin
        #1;
        if (mon_en) begin
            if (reqe) begin
                check_ctl("reqd", reqd, 1'b0);
                if (held_valid) check_uop("uop held", uop, held_uop);
                if (rdye) begin
                    if (exp_q.size() == 0) begin
                        errors++;
                        $display("Execute transfer with no instruction outstanding");
                    end else begin
                        check_uop("uop", uop, exp_q.pop_front());
                    end
                    held_valid = 1'b0;
                end else begin
                    held_uop   = uop;
                    held_valid = 1'b1;
                end
            end else if (held_valid) begin
                errors++;
                $display("reqe fell before the execute transfer");
                held_valid = 1'b0;
            end
            if (fetch_waiting) check_ctl("reqd", reqd, 1'b1);
            fetch_waiting = reqd && !rdyd;
            check_lines("int_line", int_line, '0);
        end
    end

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        instd       = '0;
        rdyd        = 1'b0;
        rdye        = 1'b0;
        lfsr        = 32'hf26068ab;
        mon_en      = 1'b0;
        bp_en       = 1'b0;
        rdye_left   = 0;
        errors      = 0;
        checks      = 0;
        test_num    = 0;
        test_errors = 0;
        op_table = '{`HS_OP_LDRI, `HS_OP_LDR, `HS_OP_LDRA, `HS_OP_STRI, `HS_OP_STR, `HS_OP_STRA,
                     `HS_OP_MOVI, `HS_OP_MOVN, `HS_OP_MOV, `HS_OP_MOVR,
                     `HS_OP_ADD, `HS_OP_ADDC, `HS_OP_SUB, `HS_OP_RSUB, `HS_OP_SUBC,
                     `HS_OP_RSUBC, `HS_OP_ADDI, `HS_OP_ADDIC, `HS_OP_SUBI, `HS_OP_RSUBI,
                     `HS_OP_SUBIC, `HS_OP_RSUBIC, `HS_OP_AND, `HS_OP_BIC, `HS_OP_OR,
                     `HS_OP_XOR, `HS_OP_ANDI, `HS_OP_BICI, `HS_OP_ORI, `HS_OP_XORI,
                     `HS_OP_CMP, `HS_OP_TST, `HS_OP_CMPI, `HS_OP_TSTI,
                     {`HS_OP_BRCH, 4'h0}, {`HS_OP_BRCL, 4'h0}};

        begin_test();
        apply_reset();
        end_test("reset");

        begin_test();
        mon_en = 1'b1;
        for (int i = 0; i < 200; i++) begin
            idx = (i < N_OPS) ? i : int'(rand_bits(6) % N_OPS);   // Every opcode first
            fetch(random_instr(op_table[idx]), 1'b1);
        end
        drain();
        end_test("random decode");

        begin_test();
        bp_en = 1'b1;
        for (int i = 0; i < 120; i++) begin
            fetch(random_instr(op_table[int'(rand_bits(6) % N_OPS)]), 1'b1);
        end
        drain();
        bp_en  = 1'b0;
        mon_en = 1'b0;
        end_test("back-pressure");

        begin_test();
        trap_case(int_instr(16'd0), 24'd1);
        trap_case(int_instr(16'd23), 24'd1 << 23);
        vec = int'(rand_bits(5) % 24);
        trap_case(int_instr(16'(vec)), 24'd1 << vec);
        end_test("INT below 24");

        begin_test();
        trap_case(int_instr(16'd24), '0);
        trap_case(int_instr(16'hffff), '0);
        trap_case(random_instr(8'h00), 24'd1);   // Holes in the opcode map
        trap_case(random_instr(8'h13), 24'd1);
        trap_case(random_instr(8'h46), 24'd1);
        trap_case(random_instr(8'h4f), 24'd1);
        trap_case(random_instr(8'h50), 24'd1);
        trap_case(random_instr(8'ha0), 24'd1);
        trap_case(random_instr(8'hff), 24'd1);
        end_test("high INT and undefined");

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
